//--- cache_ctrl.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/tag_lookup.sv
rtl/victim_lfsr.sv
rtl/data_store.sv
rtl/cache_fsm.sv
rtl/cache_top.sv
verification/cache_chk.sv
verification/cache_monitor.sv
verification/cache_tb.sv

//--- Bender.yml
package:
  name: cache_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/mem_bus_pkg.sv
      - rtl/tag_lookup.sv
      - rtl/victim_lfsr.sv
      - rtl/data_store.sv
      - rtl/cache_fsm.sv
      - rtl/cache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/cache_chk.sv
      - verification/cache_monitor.sv
      - verification/cache_tb.sv

//--- verification/cache_tb.sv
// Cache controller testbench
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_tb;
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam real CLK_PERIOD = 20.0;

    typedef struct {
        string       name;
        bit          wr;
        logic [31:0] addr;
        logic [7:0]  strb;
        logic [63:0] data;
        logic [1:0]  kind;  // 0 any, 1 hit, 2 miss
        bit          use_exp;
        logic [63:0] exp;
    } entry_t;

    logic              clk = 1'b0;
    logic              rst;
    cpu_req_t          cpu;
    logic              mem_w_ready;
    mem_r_rsp_t        mem_r_rsp;
    logic [63:0]       cpu_rdata;
    logic              cpu_r_valid;
    logic              cpu_w_ready;
    mem_w_req_t        mem_w;
    mem_r_req_t        mem_r;
    logic [1:0]        exp_kind;
    logic              exp_used;
    logic [63:0]       exp_data;
    int                mismatches;
    int                other_errors;
    int                seed = 40;
    entry_t            tests[$];
    logic [63:0]       mem [logic [28:0]];  // words written back
    logic [2:0]        wr_beat;
    logic [2:0]        rd_beat;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top cache_top_inst (
        .clk, .rst, .cpu, .mem_w_ready, .mem_r_rsp, .cpu_rdata, .cpu_r_valid,
        .cpu_w_ready, .mem_w, .mem_r
    );

    cache_monitor cache_monitor_inst (
        .clk, .rst, .cpu, .cpu_rdata, .cpu_r_valid, .cpu_w_ready, .mem_w, .mem_w_ready,
        .mem_r, .exp_kind, .exp_used, .exp_data, .mismatches, .other_errors
    );

    function automatic logic [63:0] mem_word(input logic [28:0] wa);
        if (mem.exists(wa)) return mem[wa];
        return {3'b000, wa, 3'b000, wa};
    endfunction

    // memory model stalling each beat at random
    always @(negedge clk) begin
        mem_w_ready     = ($random(seed) & 3) != 0;
        mem_r_rsp.valid = mem_r.ready && (($random(seed) & 3) != 0);
        mem_r_rsp.data  = mem_word(mem_r.addr[31:3] + rd_beat);
    end

    always @(posedge clk) begin
        if (rst) begin
            wr_beat <= '0;
            rd_beat <= '0;
        end else begin
            if (mem_w.valid && mem_w_ready) begin
                mem[mem_w.addr[31:3] + wr_beat] = mem_w.data;
                wr_beat <= wr_beat + 1'b1;
            end
            if (mem_r.ready && mem_r_rsp.valid) rd_beat <= rd_beat + 1'b1;
        end
    end

    task automatic add(input string name, input bit wr, input logic [31:0] addr,
                       input logic [7:0] strb, input logic [63:0] data, input logic [1:0] kind,
                       input bit use_exp, input logic [63:0] exp);
        entry_t e;
        e = '{name, wr, addr, strb, data, kind, use_exp, exp};
        tests.push_back(e);
    endtask

    // set 5 lines sit at tag * 0x400 + 0x140
    task automatic build_table();
        add("reset_first_read", 0, 32'h148, 8'h00, 64'h0, 2, 1, 64'h00000029_00000029);
        add("read_hit", 0, 32'h150, 8'h00, 64'h0, 1, 1, 64'h0000002a_0000002a);
        add("write_hit_partial", 1, 32'h148, 8'h0f, 64'haaaabbbb_ccccdddd, 1, 0, 64'h0);
        add("read_merged", 0, 32'h148, 8'h00, 64'h0, 1, 1, 64'h00000029_ccccdddd);
        add("evict_wr_1", 1, 32'h540, 8'hff, 64'h11111111_11111111, 2, 0, 64'h0);
        add("evict_wr_2", 1, 32'h940, 8'hff, 64'h22222222_22222222, 2, 0, 64'h0);
        add("evict_wr_3", 1, 32'hd40, 8'hff, 64'h33333333_33333333, 2, 0, 64'h0);
        add("evict_wr_4", 1, 32'h1140, 8'hff, 64'h44444444_44444444, 2, 0, 64'h0);
        add("evict_wr_5", 1, 32'h1548, 8'hf0, 64'h55555555_55555555, 2, 0, 64'h0);
        add("reread_0", 0, 32'h148, 8'h00, 64'h0, 0, 1, 64'h00000029_ccccdddd);
        add("reread_1", 0, 32'h540, 8'h00, 64'h0, 0, 1, 64'h11111111_11111111);
        add("reread_2", 0, 32'h940, 8'h00, 64'h0, 0, 1, 64'h22222222_22222222);
        add("reread_3", 0, 32'hd40, 8'h00, 64'h0, 0, 1, 64'h33333333_33333333);
        add("reread_4", 0, 32'h1140, 8'h00, 64'h0, 0, 1, 64'h44444444_44444444);
        add("reread_5", 0, 32'h1548, 8'h00, 64'h0, 0, 1, 64'h55555555_000002a9);
        add("other_set_miss", 0, 32'h2000, 8'h00, 64'h0, 2, 1, 64'h00000400_00000400);
    endtask

    task automatic apply(input entry_t e);
        @(negedge clk);
        cache_monitor_inst.test_name = e.name;
        exp_kind  = e.kind;
        exp_used  = e.use_exp;
        exp_data  = e.exp;
        cpu.rd    = !e.wr;
        cpu.wr    = e.wr;
        cpu.addr  = e.addr;
        cpu.strb  = e.strb;
        cpu.wdata = e.data;
        do @(negedge clk); while (!(cpu_r_valid || cpu_w_ready));
        @(negedge clk);
        cpu = '0;  // released in the cycle after completion
    endtask

    initial begin
        #1;
        #(tests.size() * 200 * CLK_PERIOD);
        $display("ERROR: timeout, a request did not complete in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int total;
        rst         = 1'b1;
        cpu         = '0;
        mem_w_ready = 1'b0;
        mem_r_rsp   = '0;
        exp_kind    = 2'd0;
        exp_used    = 1'b0;
        exp_data    = '0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (tests[i]) apply(tests[i]);
        repeat (4) @(negedge clk);
        total = mismatches + other_errors + cache_top_inst.cache_chk_inst.fail_cnt;
        cache_monitor_inst.report(cache_top_inst.cache_chk_inst.fail_cnt);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/cache_monitor.sv
// Cache result monitor
`timescale 1ns/1ps
`default_nettype none

module cache_monitor (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::cpu_req_t     cpu,
    input  logic [63:0]             cpu_rdata,
    input  logic                    cpu_r_valid,
    input  logic                    cpu_w_ready,
    input  mem_bus_pkg::mem_w_req_t mem_w,
    input  logic                    mem_w_ready,
    input  mem_bus_pkg::mem_r_req_t mem_r,
    input  logic [1:0]              exp_kind,  // 0 any, 1 hit, 2 miss
    input  logic                    exp_used,
    input  logic [63:0]             exp_data,
    output int                      mismatches,
    output int                      other_errors
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    string       test_name = "none";
    logic [7:0]  shadow [logic [31:0]];  // bytes written by the cpu
    int          checks = 0;
    int          lat = 0;
    logic        traffic = 1'b0;
    logic        req_d = 1'b0;
    logic        rst_d = 1'b0;
    logic [2:0]  wb_beat = '0;
    logic [63:0] want;
    logic [31:0] wb_addr;

    initial begin
        mismatches   = 0;
        other_errors = 0;
    end

    // unwritten words hold their word address in both halves
    function automatic logic [63:0] shadow_word(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] wa;
        logic [63:0] w;
        base = {addr[31:3], 3'b000};
        wa   = addr >> 3;
        for (int b = 0; b < 8; b++) begin
            if (shadow.exists(base + b)) w[b*8 +: 8] = shadow[base + b];
            else w[b*8 +: 8] = wa[(b % 4)*8 +: 8];
        end
        return w;
    endfunction

    task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
        mismatches++;
        $display("MISMATCH %s %s expected 0x%016h actual 0x%016h", test_name, what, exp, act);
    endtask

    task automatic fault(input string what);
        other_errors++;
        $display("ERROR %s: %s", test_name, what);
    endtask

    always @(posedge clk) begin
        rst_d <= rst;
        if (rst_d && (cpu_r_valid || cpu_w_ready || mem_w.valid || mem_r.ready)) begin
            fault("control outputs high after reset");
        end
        if (rst) begin
            req_d   <= 1'b0;
            wb_beat <= '0;
        end else begin
            if ((cpu.rd || cpu.wr) && !req_d) begin  // cycle 0 of a request
                lat     = 0;
                traffic = 1'b0;
            end else begin
                lat++;
            end
            traffic = traffic | mem_r.ready | mem_w.valid;
            req_d <= cpu.rd | cpu.wr;

            if (cpu_r_valid) begin
                checks++;
                want = shadow_word(cpu.addr);
                if (cpu_rdata !== want) mismatch("read vs shadow", want, cpu_rdata);
                if (exp_used && cpu_rdata !== exp_data) mismatch("read vs table", exp_data, cpu_rdata);
                if (exp_kind == 2'd1 && (lat != 2 || traffic)) fault("read hit was not a 2 cycle hit");
                if (exp_kind == 2'd2 && !traffic) fault("read miss did not refill the line");
            end

            if (cpu_w_ready) begin
                for (int b = 0; b < 8; b++) begin
                    if (cpu.strb[b]) shadow[{cpu.addr[31:3], 3'b000} + b] = cpu.wdata[b*8 +: 8];
                end
                if (exp_kind == 2'd1 && (lat != 1 || traffic)) fault("write hit was not a 1 cycle hit");
                if (exp_kind == 2'd2 && !traffic) fault("write miss did not refill the line");
            end

            if (mem_w.valid && mem_w_ready) begin
                checks++;
                wb_addr = mem_w.addr + {wb_beat, 3'b000};
                want    = shadow_word(wb_addr);
                if (mem_w.data !== want) mismatch($sformatf("write-back 0x%08h", wb_addr),
                                                  want, mem_w.data);
                wb_beat <= wb_beat + 1'b1;
            end
        end
    end

    task automatic report(input int assert_fails);
        $display("checks=%0d mismatches=%0d other_errors=%0d assertion_failures=%0d",
                 checks, mismatches, other_errors, assert_fails);
    endtask

endmodule

`default_nettype wire

//--- verification/cache_chk.sv
// Cache protocol assertions
`timescale 1ns/1ps
`default_nettype none

module cache_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    cpu_r_valid,
    input logic                    cpu_w_ready,
    input mem_bus_pkg::mem_w_req_t mem_w,
    input logic                    mem_w_ready,
    input mem_bus_pkg::mem_r_req_t mem_r
);
    import mem_bus_pkg::*;

    int fail_cnt = 0;  // read by the testbench at the end

    a_one_pulse: assert property (@(posedge clk) disable iff (rst)
        !(cpu_r_valid && cpu_w_ready))
        else begin $error("read and write completion together"); fail_cnt++; end

    a_r_valid_short: assert property (@(posedge clk) disable iff (rst)
        cpu_r_valid |=> !cpu_r_valid)
        else begin $error("cpu_r_valid longer than one cycle"); fail_cnt++; end

    a_w_ready_short: assert property (@(posedge clk) disable iff (rst)
        cpu_w_ready |=> !cpu_w_ready)
        else begin $error("cpu_w_ready longer than one cycle"); fail_cnt++; end

    a_one_burst: assert property (@(posedge clk) disable iff (rst)
        !(mem_w.valid && mem_r.ready))
        else begin $error("write and read bursts overlap"); fail_cnt++; end

    // a stalled write beat holds data and address
    a_w_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_w.valid && !mem_w_ready) |=> ($stable(mem_w.data) && $stable(mem_w.addr)))
        else begin $error("write beat changed while stalled"); fail_cnt++; end

endmodule

bind cache_top cache_chk cache_chk_inst (.*);

`default_nettype wire

//--- rtl/cache_top.sv
// Cache controller top level
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::cpu_req_t     cpu,
    input  logic                    mem_w_ready,
    input  mem_bus_pkg::mem_r_rsp_t mem_r_rsp,
    output logic [`DATA_W-1:0]      cpu_rdata,
    output logic                    cpu_r_valid,
    output logic                    cpu_w_ready,
    output mem_bus_pkg::mem_w_req_t mem_w,
    output mem_bus_pkg::mem_r_req_t mem_r
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    addr_fields_t         fields;
    logic                 hit;
    way_t                 hit_way;
    logic                 has_empty;
    way_t                 empty_way;
    tag_entry_t           sel_entry;
    way_t                 sel_way;
    way_t                 rand_way;
    logic                 lfsr_step;
    logic                 tag_we;
    way_t                 tag_way;
    tag_entry_t           tag_wdata;
    logic                 d_re;
    logic                 d_we;
    way_t                 d_way;
    logic [`WORD_W-1:0]   d_word;
    logic [`DATA_W/8-1:0] d_strb;
    logic [`DATA_W-1:0]   d_wdata;
    logic [`DATA_W-1:0]   d_rdata;
    mem_w_req_t           fsm_mem_w;  // data filled in below

    assign fields = cpu.addr;  // request is held until it completes

    tag_lookup tag_lookup_inst (
        .clk, .rst, .index(fields.index), .tag(fields.tag), .sel_way,
        .tag_we, .tag_way, .tag_wdata, .hit, .hit_way, .has_empty, .empty_way, .sel_entry
    );

    victim_lfsr victim_lfsr_inst (.clk, .rst, .step(lfsr_step), .rand_way);

    data_store data_store_inst (
        .clk, .re(d_re), .we(d_we), .way(d_way), .index(fields.index), .word(d_word),
        .strb(d_strb), .wdata(d_wdata), .rdata(d_rdata)
    );

    cache_fsm cache_fsm_inst (
        .clk, .rst, .cpu, .hit, .hit_way, .has_empty, .empty_way, .sel_entry, .rand_way,
        .mem_w_ready, .mem_r_rsp, .cpu_r_valid, .cpu_w_ready, .sel_way, .lfsr_step,
        .tag_we, .tag_way, .tag_wdata, .d_re, .d_we, .d_way, .d_word, .d_strb, .d_wdata,
        .mem_w(fsm_mem_w), .mem_r
    );

    // one read port serves both the cpu and the write-back
    assign cpu_rdata = d_rdata;
    assign mem_w     = '{valid: fsm_mem_w.valid, addr: fsm_mem_w.addr, data: d_rdata};

endmodule

`default_nettype wire

//--- rtl/cache_fsm.sv
// Cache control state machine
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module cache_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  cache_pkg::cpu_req_t     cpu,
    input  logic                    hit,
    input  cache_pkg::way_t         hit_way,
    input  logic                    has_empty,
    input  cache_pkg::way_t         empty_way,
    input  cache_pkg::tag_entry_t   sel_entry,
    input  cache_pkg::way_t         rand_way,
    input  logic                    mem_w_ready,
    input  mem_bus_pkg::mem_r_rsp_t mem_r_rsp,
    output logic                    cpu_r_valid,
    output logic                    cpu_w_ready,
    output cache_pkg::way_t         sel_way,
    output logic                    lfsr_step,
    output logic                    tag_we,
    output cache_pkg::way_t         tag_way,
    output cache_pkg::tag_entry_t   tag_wdata,
    output logic                    d_re,
    output logic                    d_we,
    output cache_pkg::way_t         d_way,
    output logic [`WORD_W-1:0]      d_word,
    output logic [`DATA_W/8-1:0]    d_strb,
    output logic [`DATA_W-1:0]      d_wdata,
    output mem_bus_pkg::mem_w_req_t mem_w,
    output mem_bus_pkg::mem_r_req_t mem_r
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    cache_state_e       state;
    addr_fields_t       cur;  // live request
    addr_fields_t       req;  // request held over a miss
    way_t               victim;
    logic [`WORD_W-1:0] beat;
    logic               w_valid;
    logic               req_seen;
    logic               miss;
    logic               last_beat;

    assign cur       = cpu.addr;
    // a read is still high in its completion cycle, do not take it twice
    assign req_seen  = cpu.wr | (cpu.rd & ~cpu_r_valid);
    assign miss      = req_seen & ~hit;
    assign last_beat = (beat == `WORD_W'(BURST_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= C_IDLE;
            beat        <= '0;
            w_valid     <= 1'b0;
            cpu_r_valid <= 1'b0;
        end else begin
            cpu_r_valid <= (state == C_R_HIT);  // data arrives one cycle after the read
            case (state)
                C_IDLE: begin
                    beat <= '0;
                    if (req_seen) begin
                        if (hit) begin
                            state <= cpu.wr ? C_W_HIT : C_R_HIT;
                        end else if (!has_empty && sel_entry.dirty) begin
                            state <= C_W_MEM;
                        end else begin
                            state <= C_R_MEM;
                        end
                    end
                end
                C_R_HIT, C_W_HIT: begin
                    state <= C_IDLE;
                end
                C_W_MEM: begin
                    if (!w_valid) begin
                        w_valid <= 1'b1;  // word 0 now in the read register
                    end else if (mem_w_ready) begin
                        beat <= beat + 1'b1;  // wraps to 0 for the refill
                        if (last_beat) begin
                            w_valid <= 1'b0;
                            state   <= C_R_MEM;
                        end
                    end
                end
                C_R_MEM: begin
                    if (mem_r_rsp.valid) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= C_IDLE;  // request replays as a hit
                        end
                    end
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == C_IDLE) && miss) begin
            req    <= cur;
            victim <= has_empty ? empty_way : rand_way;
        end
    end

    assign cpu_w_ready = (state == C_W_HIT);
    assign sel_way     = (state == C_IDLE) ? rand_way : victim;
    assign lfsr_step   = (state == C_IDLE) & miss & ~has_empty;

    // line-aligned burst addresses
    assign mem_w = '{valid: w_valid,
                     addr:  {sel_entry.tag, req.index, {(`WORD_W + `BYTE_W){1'b0}}},
                     data:  '0};
    assign mem_r = '{ready: (state == C_R_MEM),
                     addr:  {req.tag, req.index, {(`WORD_W + `BYTE_W){1'b0}}}};

    always_comb begin
        d_re      = 1'b0;
        d_we      = 1'b0;
        d_way     = hit_way;
        d_word    = cur.word;
        d_strb    = cpu.strb;
        d_wdata   = cpu.wdata;
        tag_we    = 1'b0;
        tag_way   = hit_way;
        tag_wdata = '{valid: 1'b1, dirty: 1'b1, tag: cur.tag};
        case (state)
            C_R_HIT: begin
                d_re = 1'b1;
            end
            C_W_HIT: begin
                d_we   = 1'b1;
                tag_we = 1'b1;  // mark dirty
            end
            C_W_MEM: begin
                d_way     = victim;
                tag_way   = victim;
                tag_wdata = '0;  // victim invalid after the last beat
                if (!w_valid) begin
                    d_re   = 1'b1;
                    d_word = beat;
                end else begin
                    d_word = beat + 1'b1;  // read ahead of the accepted beat
                    d_re   = mem_w_ready & ~last_beat;
                    tag_we = mem_w_ready & last_beat;
                end
            end
            C_R_MEM: begin
                d_way     = victim;
                tag_way   = victim;
                d_word    = beat;
                d_strb    = '1;
                d_wdata   = mem_r_rsp.data;
                d_we      = mem_r_rsp.valid;
                tag_we    = mem_r_rsp.valid & last_beat;
                tag_wdata = '{valid: 1'b1, dirty: 1'b0, tag: req.tag};
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/data_store.sv
// Cache line data array
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module data_store (
    input  logic                 clk,
    input  logic                 re,
    input  logic                 we,
    input  cache_pkg::way_t      way,
    input  logic [`INDEX_W-1:0]  index,
    input  logic [`WORD_W-1:0]   word,
    input  logic [`DATA_W/8-1:0] strb,
    input  logic [`DATA_W-1:0]   wdata,
    output logic [`DATA_W-1:0]   rdata
);
    localparam int DEPTH = `CACHE_WAYS * `CACHE_SETS * `LINE_BEATS;  // 512 words, 4 KB

    logic [`DATA_W-1:0]       mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] addr;

    assign addr = {way, index, word};

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < `DATA_W / 8; b++) begin
                if (strb[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered read port, holds its word while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/victim_lfsr.sv
// Random victim way
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module victim_lfsr (
    input  logic            clk,
    input  logic            rst,
    input  logic            step,
    output cache_pkg::way_t rand_way
);
    import cache_pkg::*;

    logic [7:0] lfsr;
    logic       feedback;

    // x^8 + x^6 + x^5 + x^4 + 1, fibonacci form
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= 8'(`LFSR_SEED);
        end else if (step) begin
            lfsr <= {lfsr[6:0], feedback};  // one step per full-set miss
        end
    end

    assign rand_way = lfsr[$bits(way_t)-1:0];

endmodule

`default_nettype wire

//--- rtl/tag_lookup.sv
// Tag store and compare
`timescale 1ns/1ps
`default_nettype none

`include "cache_config.svh"

module tag_lookup (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`INDEX_W-1:0]   index,
    input  logic [`TAG_W-1:0]     tag,
    input  cache_pkg::way_t       sel_way,
    input  logic                  tag_we,
    input  cache_pkg::way_t       tag_way,
    input  cache_pkg::tag_entry_t tag_wdata,
    output logic                  hit,
    output cache_pkg::way_t       hit_way,
    output logic                  has_empty,
    output cache_pkg::way_t       empty_way,
    output cache_pkg::tag_entry_t sel_entry
);
    import cache_pkg::*;

    tag_entry_t tags [`CACHE_SETS][`CACHE_WAYS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    tags[s][w] <= '0;  // all lines invalid
                end
            end
        end else if (tag_we) begin
            tags[index][tag_way] <= tag_wdata;
        end
    end

    // scan from the top way down so the lowest match is kept
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        has_empty = 1'b0;
        empty_way = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (tags[index][w].valid && (tags[index][w].tag == tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
            if (!tags[index][w].valid) begin
                has_empty = 1'b1;
                empty_way = way_t'(w);
            end
        end
    end

    // victim dirty bit and write-back tag
    assign sel_entry = tags[index][sel_way];

endmodule

`default_nettype wire

//--- rtl/mem_bus_pkg.sv
// Memory bus types
`default_nettype none

`include "cache_config.svh"

package mem_bus_pkg;

    // every burst is one whole line: LINE_BEATS incrementing beats of 8 bytes,
    // starting at the line-aligned address given with the request
    localparam int unsigned BURST_BEATS = `LINE_BEATS;

    // write burst, one beat per cycle with valid and ready high
    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] addr;  // line base, fixed for the burst
        logic [`DATA_W-1:0] data;
    } mem_w_req_t;

    // read burst request, ready held for the whole refill
    typedef struct packed {
        logic               ready;
        logic [`ADDR_W-1:0] addr;  // line base
    } mem_r_req_t;

    typedef struct packed {
        logic               valid;
        logic [`DATA_W-1:0] data;
    } mem_r_rsp_t;

endpackage

`default_nettype wire

//--- rtl/cache_pkg.sv
// Cache-side types
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

    // cpu address split as seen by the cache
    typedef struct packed {
        logic [`TAG_W-1:0]   tag;
        logic [`INDEX_W-1:0] index;
        logic [`WORD_W-1:0]  word;
        logic [`BYTE_W-1:0]  byte_ofs;  // ignored, word aligned access
    } addr_fields_t;

    typedef struct packed {
        logic              valid;
        logic              dirty;
        logic [`TAG_W-1:0] tag;
    } tag_entry_t;

    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

    typedef enum logic [2:0] {
        C_IDLE,  // waiting for a request
        C_R_HIT,  // data read for a read hit
        C_W_HIT,  // byte write for a write hit
        C_W_MEM,  // write-back of a dirty victim
        C_R_MEM  // line refill
    } cache_state_e;

    typedef struct packed {
        logic                 rd;
        logic                 wr;
        logic [`ADDR_W-1:0]   addr;
        logic [`DATA_W/8-1:0] strb;
        logic [`DATA_W-1:0]   wdata;
    } cpu_req_t;

endpackage

`default_nettype wire

//--- rtl/cache_config.svh
// Cache geometry
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry
`define CACHE_WAYS 4  // ways per set
`define CACHE_SETS 16  // sets
`define LINE_BEATS 8  // 64-bit words per line

// bus widths
`define DATA_W 64
`define ADDR_W 32

// address field widths, tag takes the rest
`define INDEX_W 4  // log2 of CACHE_SETS
`define WORD_W 3  // log2 of LINE_BEATS
`define BYTE_W 3  // byte within a word
`define TAG_W (`ADDR_W - `INDEX_W - `WORD_W - `BYTE_W)

`define LFSR_SEED 1  // must not be zero

`endif
